// ==== design/data_ram.sv ====
// Single-port data RAM with byte enables and a fixed one-cycle ack, driven by the LSU
`timescale 1ns/1ps
`include "lsu_defs.svh"

module data_ram (
  input  logic                   clk_i,
  input  logic                   rstn_i,
  input  logic                   stb_i,
  input  lsu_mem_pkg::addr_t     addr_i,
  input  lsu_mem_pkg::byte_en_t  we_i,      // All zero for a read
  input  lsu_mem_pkg::word_t     wdata_i,
  output logic                   ack_o,
  output logic                   err_o,
  output lsu_mem_pkg::word_t     rdata_o
);

  import lsu_mem_pkg::*;

  localparam int unsigned RAM_BYTES = `LSU_RAM_WORDS * (`LSU_DATA_WIDTH / 8);

  word_t    mem [`LSU_RAM_WORDS];
  ram_idx_t word_idx;
  logic     in_range;

  ////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////
  assign word_idx = addr_i[$bits(byte_off_t) +: $bits(ram_idx_t)];
  assign in_range = (addr_i < addr_t'(RAM_BYTES));

  // Write enabled lanes, or read the whole word
  always_ff @(posedge clk_i) begin
    if (stb_i && in_range) begin
      for (int b = 0; b < $bits(byte_en_t); b++) begin
        if (we_i[b]) begin
          mem[word_idx][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
      if (~|we_i) begin
        rdata_o <= mem[word_idx];   // Read port holds its value during writes
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Response
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      ack_o <= 1'b0;
      err_o <= 1'b0;
    end else begin
      ack_o <= stb_i;               // Never stalls
      err_o <= stb_i && !in_range;  // Out of range, nothing written
    end
  end

endmodule

// ==== design/lsu.sv ====
// Load-store unit that checks alignment, places store lanes and extends load data for writeback
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu (
  input  logic                   clk_i,
  input  logic                   rstn_i,
  // Request from the decoder
  input  logic                   ctrl_valid_i,       // One-cycle strobe per operation
  input  lsu_ctrl_pkg::lsu_op_e  ctrl_i,
  input  lsu_mem_pkg::addr_t     addr_i,
  input  lsu_mem_pkg::word_t     wdata_i,
  input  lsu_mem_pkg::reg_idx_t  regdest_i,
  // Data RAM
  output logic                   mem_stb_o,
  output lsu_mem_pkg::addr_t     mem_addr_o,
  output lsu_mem_pkg::byte_en_t  mem_we_o,
  output lsu_mem_pkg::word_t     mem_wdata_o,
  input  logic                   mem_ack_i,
  input  logic                   mem_err_i,
  input  lsu_mem_pkg::word_t     mem_rdata_i,
  // Register file writeback
  output logic                   wb_valid_o,
  output lsu_mem_pkg::word_t     wb_data_o,
  output lsu_mem_pkg::reg_idx_t  wb_regdest_o,
  // Exceptions
  output logic                   misaligned_load_o,
  output logic                   misaligned_store_o,
  output logic                   bus_error_o,
  output lsu_mem_pkg::addr_t     exception_addr_o
);

  import lsu_ctrl_pkg::*;
  import lsu_mem_pkg::*;

  byte_off_t  req_off;         // Lane offset of the incoming request
  lsu_size_t  req_size;
  logic       req_store;
  logic       req_misaligned;
  logic       mis_load;
  logic       mis_store;
  byte_en_t   lane_we;
  word_t      lane_wdata;

  // Control pipe, stage 1 follows mem_stb_o and stage 2 follows mem_ack_i
  lsu_op_e    s1_op;
  byte_off_t  s1_off;
  reg_idx_t   s1_rd;
  logic       s1_mis;
  lsu_op_e    s2_op;
  byte_off_t  s2_off;
  reg_idx_t   s2_rd;
  logic       s2_mis;

  logic [7:0]  lane_byte;
  logic [15:0] lane_half;
  word_t       load_data;

  ////////////////////////////////////////////////////////////
  // Request decode
  ////////////////////////////////////////////////////////////
  assign req_off   = addr_i[1:0];
  assign req_size  = op_size(ctrl_i);
  assign req_store = op_is_store(ctrl_i);

  always_comb begin
    case (req_size)
      LSU_SIZE_H: req_misaligned = req_off[0];
      LSU_SIZE_W: req_misaligned = |req_off;
      default:    req_misaligned = 1'b0;   // Bytes are always aligned
    endcase
  end

  assign mis_load  = ctrl_valid_i & ~req_store & req_misaligned;
  assign mis_store = ctrl_valid_i & req_store & req_misaligned;

  // Data is replicated over the lanes and the enables pick the live ones
  always_comb begin
    lane_we    = '0;
    lane_wdata = wdata_i;
    case (req_size)
      LSU_SIZE_B: begin
        lane_we    = byte_en_t'(1) << req_off;
        lane_wdata = {4{wdata_i[7:0]}};
      end
      LSU_SIZE_H: begin
        lane_we    = req_off[1] ? 4'b1100 : 4'b0011;
        lane_wdata = {2{wdata_i[15:0]}};
      end
      default: lane_we = 4'b1111;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Memory request and exception flags
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      mem_stb_o          <= 1'b0;
      mem_we_o           <= '0;
      misaligned_load_o  <= 1'b0;
      misaligned_store_o <= 1'b0;
      exception_addr_o   <= '0;
    end else begin
      mem_stb_o          <= ctrl_valid_i;
      // Misaligned stores become harmless reads
      mem_we_o           <= (ctrl_valid_i && req_store && !req_misaligned) ? lane_we : '0;
      misaligned_load_o  <= mis_load;
      misaligned_store_o <= mis_store;
      if (ctrl_valid_i) begin
        exception_addr_o <= addr_i;   // Last accepted address
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (ctrl_valid_i) begin
      mem_addr_o  <= addr_i;
      mem_wdata_o <= lane_wdata;
    end
  end

  // Each stage moves with its request so back-to-back loads keep their own context
  always_ff @(posedge clk_i) begin
    if (ctrl_valid_i) begin
      s1_op  <= ctrl_i;
      s1_off <= req_off;
      s1_rd  <= regdest_i;
      s1_mis <= mis_load;
    end
    if (mem_stb_o) begin
      s2_op  <= s1_op;
      s2_off <= s1_off;
      s2_rd  <= s1_rd;
      s2_mis <= s1_mis;
    end
  end

  ////////////////////////////////////////////////////////////
  // Load extraction and writeback
  ////////////////////////////////////////////////////////////
  assign lane_byte = mem_rdata_i[{s2_off, 3'b000} +: 8];
  assign lane_half = s2_off[1] ? mem_rdata_i[31:16] : mem_rdata_i[15:0];

  always_comb begin
    case (op_size(s2_op))
      LSU_SIZE_B: begin
        if (op_is_unsigned(s2_op)) begin
          load_data = {{(`LSU_DATA_WIDTH-8){1'b0}}, lane_byte};
        end else begin
          load_data = {{(`LSU_DATA_WIDTH-8){lane_byte[7]}}, lane_byte};  // Sign from bit 7
        end
      end
      LSU_SIZE_H: begin
        if (op_is_unsigned(s2_op)) begin
          load_data = {{(`LSU_DATA_WIDTH-16){1'b0}}, lane_half};
        end else begin
          load_data = {{(`LSU_DATA_WIDTH-16){lane_half[15]}}, lane_half};
        end
      end
      default: load_data = mem_rdata_i;  // Full word
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      wb_valid_o  <= 1'b0;
      bus_error_o <= 1'b0;
    end else begin
      // No writeback for stores, misaligned loads or bus errors
      wb_valid_o  <= mem_ack_i && !op_is_store(s2_op) && !s2_mis && !mem_err_i;
      bus_error_o <= mem_ack_i && mem_err_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (mem_ack_i) begin
      wb_data_o    <= load_data;
      wb_regdest_o <= s2_rd;
    end
  end

endmodule

// ==== design/lsu_ctrl_pkg.sv ====
// Operation codes and decode helpers for requests passed from the decoder to the LSU
package lsu_ctrl_pkg;

  ////////////////////////////////////////////////////////////
  // Operation encoding
  ////////////////////////////////////////////////////////////
  typedef logic [3:0] lsu_ctrl_t;  // Raw code with store flag in bit 3
  typedef logic [1:0] lsu_size_t;  // Access size in the low two bits

  localparam lsu_size_t LSU_SIZE_B = 2'd0;
  localparam lsu_size_t LSU_SIZE_H = 2'd1;
  localparam lsu_size_t LSU_SIZE_W = 2'd2;

  // Bit 2 marks a zero-extending load
  typedef enum lsu_ctrl_t {
    LSU_LB  = 4'b0000,
    LSU_LH  = 4'b0001,
    LSU_LW  = 4'b0010,
    LSU_LBU = 4'b0100,
    LSU_LHU = 4'b0101,
    LSU_SB  = 4'b1000,
    LSU_SH  = 4'b1001,
    LSU_SW  = 4'b1010
  } lsu_op_e;

  function automatic logic op_is_store(lsu_op_e op);
    return op[3];
  endfunction

  function automatic logic op_is_unsigned(lsu_op_e op);
    return op[2];
  endfunction

  function automatic lsu_size_t op_size(lsu_op_e op);
    return op[1:0];
  endfunction

endpackage

// ==== design/lsu_defs.svh ====
// Sizing macros for the load-store path, included by the packages and any module that sizes storage
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

////////////////////////////////////////////////////////////
// Datapath
////////////////////////////////////////////////////////////
`define LSU_DATA_WIDTH   32    // Word width in bits
`define LSU_REG_COUNT    32    // Architectural registers

////////////////////////////////////////////////////////////
// Memory and timing
////////////////////////////////////////////////////////////
// Words in the data RAM, valid bytes are 0 to 4*depth-1
`define LSU_RAM_WORDS    256

`define LSU_LOAD_LATENCY 3     // Accept edge to wb_valid_o in cycles

`endif

// ==== design/lsu_mem_pkg.sv ====
// Vector types for data, addresses and indices, imported by the LSU, data RAM and register file
`include "lsu_defs.svh"

package lsu_mem_pkg;

  ////////////////////////////////////////////////////////////
  // Bus and storage widths
  ////////////////////////////////////////////////////////////
  typedef logic [`LSU_DATA_WIDTH-1:0]             word_t;
  typedef logic [31:0]                            addr_t;      // Byte address
  typedef logic [`LSU_DATA_WIDTH/8-1:0]           byte_en_t;   // One bit per lane
  typedef logic [$clog2(`LSU_DATA_WIDTH/8)-1:0]   byte_off_t;

  // Indices into the storage arrays
  typedef logic [$clog2(`LSU_REG_COUNT)-1:0]      reg_idx_t;
  typedef logic [$clog2(`LSU_RAM_WORDS)-1:0]      ram_idx_t;

endpackage

// ==== design/lsu_subsys.sv ====
// Top level of the load-store path that ties the LSU to the data RAM and the register file
`timescale 1ns/1ps

module lsu_subsys (
  input  logic                   clk_i,
  input  logic                   rstn_i,
  // Request
  input  logic                   ctrl_valid_i,
  input  lsu_ctrl_pkg::lsu_op_e  ctrl_i,
  input  lsu_mem_pkg::addr_t     addr_i,
  input  lsu_mem_pkg::word_t     wdata_i,
  input  lsu_mem_pkg::reg_idx_t  regdest_i,
  // Register inspection
  input  lsu_mem_pkg::reg_idx_t  rf_raddr_i,
  output lsu_mem_pkg::word_t     rf_rdata_o,
  // Writeback
  output logic                   wb_valid_o,
  output lsu_mem_pkg::word_t     wb_data_o,
  output lsu_mem_pkg::reg_idx_t  wb_regdest_o,
  // Exceptions
  output logic                   misaligned_load_o,
  output logic                   misaligned_store_o,
  output logic                   bus_error_o,
  output lsu_mem_pkg::addr_t     exception_addr_o
);

  import lsu_mem_pkg::*;

  ////////////////////////////////////////////////////////////
  // LSU to RAM
  ////////////////////////////////////////////////////////////
  logic     mem_stb;
  addr_t    mem_addr;
  byte_en_t mem_we;
  word_t    mem_wdata;
  logic     mem_ack;
  logic     mem_err;
  word_t    mem_rdata;

  lsu i_lsu (
    .clk_i              (clk_i),
    .rstn_i             (rstn_i),
    .ctrl_valid_i       (ctrl_valid_i),
    .ctrl_i             (ctrl_i),
    .addr_i             (addr_i),
    .wdata_i            (wdata_i),
    .regdest_i          (regdest_i),
    .mem_stb_o          (mem_stb),
    .mem_addr_o         (mem_addr),
    .mem_we_o           (mem_we),
    .mem_wdata_o        (mem_wdata),
    .mem_ack_i          (mem_ack),
    .mem_err_i          (mem_err),
    .mem_rdata_i        (mem_rdata),
    .wb_valid_o         (wb_valid_o),
    .wb_data_o          (wb_data_o),
    .wb_regdest_o       (wb_regdest_o),
    .misaligned_load_o  (misaligned_load_o),
    .misaligned_store_o (misaligned_store_o),
    .bus_error_o        (bus_error_o),
    .exception_addr_o   (exception_addr_o)
  );

  data_ram i_data_ram (
    .clk_i   (clk_i),
    .rstn_i  (rstn_i),
    .stb_i   (mem_stb),
    .addr_i  (mem_addr),
    .we_i    (mem_we),
    .wdata_i (mem_wdata),
    .ack_o   (mem_ack),
    .err_o   (mem_err),
    .rdata_o (mem_rdata)
  );

  // Writeback goes out of the top and into the register file
  reg_file i_reg_file (
    .clk_i   (clk_i),
    .rstn_i  (rstn_i),
    .we_i    (wb_valid_o),
    .waddr_i (wb_regdest_o),
    .wdata_i (wb_data_o),
    .raddr_i (rf_raddr_i),
    .rdata_o (rf_rdata_o)
  );

endmodule

// ==== design/reg_file.sv ====
// Register file taking LSU load writebacks, with one combinational read port for inspection
`timescale 1ns/1ps
`include "lsu_defs.svh"

module reg_file (
  input  logic                   clk_i,
  input  logic                   rstn_i,
  input  logic                   we_i,
  input  lsu_mem_pkg::reg_idx_t  waddr_i,
  input  lsu_mem_pkg::word_t     wdata_i,
  input  lsu_mem_pkg::reg_idx_t  raddr_i,
  output lsu_mem_pkg::word_t     rdata_o
);

  import lsu_mem_pkg::*;

  word_t regs [`LSU_REG_COUNT];

  // Writes to x0 are dropped
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      for (int i = 0; i < `LSU_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  assign rdata_o = regs[raddr_i];  // x0 keeps its reset value of zero

endmodule

// ==== lsu_subsys.f ====
+incdir+design
design/lsu_ctrl_pkg.sv
design/lsu_mem_pkg.sv
design/lsu.sv
design/data_ram.sv
design/reg_file.sv
design/lsu_subsys.sv
tb/lsu_subsys_asserts.sv
tb/tb_lsu_subsys.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the load-store path simulation with Verilator

LOG=sim.log
FAIL_MSG='*** TEST FAILED ***'

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f lsu_subsys.f \
  --top-module tb_lsu_subsys \
  -Mdir obj_dir -o sim_lsu_subsys
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_lsu_subsys > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qF "$FAIL_MSG" "$LOG"; then
  echo "Simulation reported failure, see $LOG"
  exit 1
fi

echo "Simulation finished without failure"
exit 0

// ==== tb/lsu_subsys_asserts.sv ====
// Bound checker for the load-store path top level, flags protocol and reset violations
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_subsys_asserts (
  input logic       clk_i,
  input logic       rstn_i,
  input logic       ctrl_valid_i,
  input logic [3:0] ctrl_i,           // Raw op code, bit 3 marks a store
  input logic       wb_valid_i,
  input logic       misaligned_load_i,
  input logic       misaligned_store_i,
  input logic       bus_error_i,
  input logic [3:0] mem_we_i
);

  ////////////////////////////////////////////////////////////
  // Writeback needs a load accepted LOAD_LATENCY cycles back
  ////////////////////////////////////////////////////////////
  a_wb_from_load: assert property (@(posedge clk_i) disable iff (!rstn_i)
    wb_valid_i |-> ($past(ctrl_valid_i, `LSU_LOAD_LATENCY) &&
                    !$past(ctrl_i[3], `LSU_LOAD_LATENCY)))
    else $error("Writeback without a matching load");

  // Flags clear on the edge that samples reset
  a_flags_reset: assert property (@(posedge clk_i)
    !rstn_i |=> (!misaligned_load_i && !misaligned_store_i && !bus_error_i))
    else $error("Exception flag high after reset");

  a_no_write_misaligned: assert property (@(posedge clk_i) disable iff (!rstn_i)
    misaligned_store_i |-> (mem_we_i == 4'b0000))   // Store must be dropped
    else $error("Byte enables active on a misaligned store");

endmodule

bind lsu_subsys lsu_subsys_asserts i_lsu_subsys_asserts (
  .clk_i              (clk_i),
  .rstn_i             (rstn_i),
  .ctrl_valid_i       (ctrl_valid_i),
  .ctrl_i             (ctrl_i),
  .wb_valid_i         (wb_valid_o),
  .misaligned_load_i  (misaligned_load_o),
  .misaligned_store_i (misaligned_store_o),
  .bus_error_i        (bus_error_o),
  .mem_we_i           (mem_we)
);

// ==== tb/lsu_vectors.txt ====
# op(hex: 0 LB 1 LH 2 LW 4 LBU 5 LHU 8 SB 9 SH A SW) addr wdata regdest expected_wb
# expected_wb is only used for loads that write back, other lines carry zero
a 00000010 11223344 00 00000000
2 00000010 00000000 05 11223344
a 00000020 00000000 00 00000000
8 00000020 000000a1 00 00000000
8 00000021 000000b2 00 00000000
8 00000022 000000c3 00 00000000
8 00000023 000000d4 00 00000000
2 00000020 00000000 06 d4c3b2a1
a 00000024 ffffffff 00 00000000
9 00000024 00001234 00 00000000
9 00000026 0000abcd 00 00000000
2 00000024 00000000 07 abcd1234
a 00000028 80ff7f01 00 00000000
0 00000028 00000000 08 00000001
0 00000029 00000000 09 0000007f
0 0000002a 00000000 0a ffffffff
0 0000002b 00000000 0b ffffff80
4 0000002a 00000000 0c 000000ff
4 0000002b 00000000 0d 00000080
4 00000028 00000000 0e 00000001
4 00000029 00000000 0e 0000007f
1 00000028 00000000 0f 00007f01
1 0000002a 00000000 10 ffff80ff
5 00000028 00000000 11 00007f01
5 0000002a 00000000 12 000080ff
1 00000026 00000000 13 ffffabcd
5 00000026 00000000 14 0000abcd
1 00000029 00000000 15 00000000
2 0000002a 00000000 16 00000000
9 0000002b 0000dead 00 00000000
a 00000021 deadbeef 00 00000000
2 00000028 00000000 17 80ff7f01
2 00000020 00000000 18 d4c3b2a1
2 00000400 00000000 19 00000000
a 00000800 cafef00d 00 00000000
a 000003fc 5a5a5a5a 00 00000000
0 000003ff 00000000 1a 0000005a
2 00001000 00000000 1b 00000000
2 00000010 00000000 1c 11223344
2 00000024 00000000 1d abcd1234
4 000003ff 00000000 1e 0000005a
1 00000028 00000000 1f 00007f01
2 00000010 00000000 00 11223344

// ==== tb/tb_lsu_subsys.sv ====
// Replays the vector file into the load-store path and checks writebacks, flags and registers
`timescale 1ns/1ps
`include "lsu_defs.svh"

module tb_lsu_subsys;

  import lsu_ctrl_pkg::*;
  import lsu_mem_pkg::*;

  localparam int    MAX_VEC   = 128;
  localparam addr_t RAM_LIMIT = addr_t'(`LSU_RAM_WORDS * 4);  // First invalid byte

  logic     clk_i;
  logic     rstn_i;
  logic     ctrl_valid_i;
  lsu_op_e  ctrl_i;
  addr_t    addr_i;
  word_t    wdata_i;
  reg_idx_t regdest_i;
  reg_idx_t rf_raddr_i;
  word_t    rf_rdata_o;
  logic     wb_valid_o;
  word_t    wb_data_o;
  reg_idx_t wb_regdest_o;
  logic     misaligned_load_o;
  logic     misaligned_store_o;
  logic     bus_error_o;
  addr_t    exception_addr_o;

  // Vector storage
  logic [3:0] vec_op    [MAX_VEC];
  addr_t      vec_addr  [MAX_VEC];
  word_t      vec_wdata [MAX_VEC];
  reg_idx_t   vec_rd    [MAX_VEC];
  word_t      vec_exp   [MAX_VEC];
  int         vec_cnt;

  // Scoreboard
  word_t    exp_data_q [$];
  reg_idx_t exp_rd_q   [$];
  word_t    exp_regs   [`LSU_REG_COUNT];
  logic [2:0] wb_pipe;          // Expected wb_valid_o with one bit per cycle in flight
  logic [2:0] berr_pipe;        // Expected bus_error_o
  logic     mis_ld_next;
  logic     mis_st_next;
  addr_t    last_addr;          // Address of the last accepted request

  int     err_cnt;
  int     chk_cnt;
  int     cycle_cnt;
  int     cycle_limit;
  integer seed;

  lsu_subsys i_lsu_subsys (
    .clk_i              (clk_i),
    .rstn_i             (rstn_i),
    .ctrl_valid_i       (ctrl_valid_i),
    .ctrl_i             (ctrl_i),
    .addr_i             (addr_i),
    .wdata_i            (wdata_i),
    .regdest_i          (regdest_i),
    .rf_raddr_i         (rf_raddr_i),
    .rf_rdata_o         (rf_rdata_o),
    .wb_valid_o         (wb_valid_o),
    .wb_data_o          (wb_data_o),
    .wb_regdest_o       (wb_regdest_o),
    .misaligned_load_o  (misaligned_load_o),
    .misaligned_store_o (misaligned_store_o),
    .bus_error_o        (bus_error_o),
    .exception_addr_o   (exception_addr_o)
  );

  ////////////////////////////////////////////////////////////
  // Reference rules
  ////////////////////////////////////////////////////////////
  function automatic logic store_op(logic [3:0] op);
    return (op == LSU_SB) || (op == LSU_SH) || (op == LSU_SW);
  endfunction

  // Halfwords need an even address and words a multiple of four
  function automatic logic misaligned_for(logic [3:0] op, addr_t a);
    if ((op == LSU_LH) || (op == LSU_LHU) || (op == LSU_SH)) begin
      return a[0];
    end else if ((op == LSU_LW) || (op == LSU_SW)) begin
      return a[1:0] != 2'b00;
    end
    return 1'b0;
  endfunction

  task automatic report_mismatch(string name, logic [31:0] exp_v, logic [31:0] act_v);
    $display("Error at %0t: %s expected %h, got %h", $time, name, exp_v, act_v);
    err_cnt++;
  endtask

  task automatic load_vectors();
    integer fd;
    integer n;
    string  line;
    logic [31:0] f_op;
    logic [31:0] f_addr;
    logic [31:0] f_wdata;
    logic [31:0] f_rd;
    logic [31:0] f_exp;
    vec_cnt = 0;
    fd = $fopen("tb/lsu_vectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vector file tb/lsu_vectors.txt");
      err_cnt++;
    end else begin
      while (!$feof(fd) && (vec_cnt < MAX_VEC)) begin
        n = $fgets(line, fd);
        if ((n > 0) && (line.getc(0) != 8'h23)) begin   // Skip comment lines
          n = $sscanf(line, "%h %h %h %h %h", f_op, f_addr, f_wdata, f_rd, f_exp);
          if (n == 5) begin
            vec_op[vec_cnt]    = f_op[3:0];
            vec_addr[vec_cnt]  = f_addr;
            vec_wdata[vec_cnt] = f_wdata;
            vec_rd[vec_cnt]    = f_rd[4:0];
            vec_exp[vec_cnt]   = f_exp;
            vec_cnt++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Clock and timeout
  ////////////////////////////////////////////////////////////
  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if ((cycle_limit > 0) && (cycle_cnt > cycle_limit)) begin
      $display("Timeout after %0d cycles, writebacks still pending: %0d",
               cycle_cnt, exp_data_q.size());
      $display("Checks: %0d  Errors: %0d", chk_cnt, err_cnt + 1);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Output monitor sampled mid-cycle
  ////////////////////////////////////////////////////////////
  always @(negedge clk_i) begin
    if (!rstn_i) begin
      wb_pipe     <= '0;
      berr_pipe   <= '0;
      mis_ld_next <= 1'b0;
      mis_st_next <= 1'b0;
      last_addr   <= '0;
    end else begin
      chk_cnt++;
      if (misaligned_load_o !== mis_ld_next) begin
        report_mismatch("misaligned_load_o", 32'(mis_ld_next), 32'(misaligned_load_o));
      end
      if (misaligned_store_o !== mis_st_next) begin
        report_mismatch("misaligned_store_o", 32'(mis_st_next), 32'(misaligned_store_o));
      end
      if (exception_addr_o !== last_addr) begin
        report_mismatch("exception_addr_o", last_addr, exception_addr_o);
      end
      if (bus_error_o !== berr_pipe[2]) begin
        report_mismatch("bus_error_o", 32'(berr_pipe[2]), 32'(bus_error_o));
      end
      if (wb_valid_o !== wb_pipe[2]) begin
        report_mismatch("wb_valid_o", 32'(wb_pipe[2]), 32'(wb_valid_o));
      end
      if (wb_valid_o === 1'b1) begin
        if (exp_data_q.size() == 0) begin
          $display("Error at %0t: writeback seen with no load pending", $time);
          err_cnt++;
        end else begin
          if (wb_data_o !== exp_data_q[0]) begin
            report_mismatch("wb_data_o", exp_data_q[0], wb_data_o);
          end
          if (wb_regdest_o !== exp_rd_q[0]) begin
            report_mismatch("wb_regdest_o", 32'(exp_rd_q[0]), 32'(wb_regdest_o));
          end
          void'(exp_data_q.pop_front());
          void'(exp_rd_q.pop_front());
        end
      end
      // Request on the inputs now is accepted at the next rising edge
      mis_ld_next   <= ctrl_valid_i && !store_op(ctrl_i) && misaligned_for(ctrl_i, addr_i);
      mis_st_next   <= ctrl_valid_i && store_op(ctrl_i) && misaligned_for(ctrl_i, addr_i);
      if (ctrl_valid_i) begin
        last_addr <= addr_i;
      end
      wb_pipe   <= {wb_pipe[1:0], ctrl_valid_i && !store_op(ctrl_i) &&
                    !misaligned_for(ctrl_i, addr_i) && (addr_i < RAM_LIMIT)};
      berr_pipe <= {berr_pipe[1:0], ctrl_valid_i && (addr_i >= RAM_LIMIT)};
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////
  initial begin
    int gap;
    seed         = 32'h94f4015c;
    err_cnt      = 0;
    chk_cnt      = 0;
    cycle_cnt    = 0;
    cycle_limit  = 0;
    rstn_i       = 1'b0;
    ctrl_valid_i = 1'b0;
    ctrl_i       = LSU_LB;
    addr_i       = '0;
    wdata_i      = '0;
    regdest_i    = '0;
    rf_raddr_i   = '0;
    for (int r = 0; r < `LSU_REG_COUNT; r++) begin
      exp_regs[r] = '0;
    end

    load_vectors();
    cycle_limit = vec_cnt * 8 + 100;

    repeat (4) @(posedge clk_i);
    rstn_i <= 1'b1;

    for (int i = 0; i < vec_cnt; i++) begin
      @(posedge clk_i);
      ctrl_valid_i <= 1'b1;
      ctrl_i       <= lsu_op_e'(vec_op[i]);
      addr_i       <= vec_addr[i];
      wdata_i      <= vec_wdata[i];
      regdest_i    <= vec_rd[i];
      if (!store_op(vec_op[i]) && !misaligned_for(vec_op[i], vec_addr[i]) &&
          (vec_addr[i] < RAM_LIMIT)) begin
        exp_data_q.push_back(vec_exp[i]);
        exp_rd_q.push_back(vec_rd[i]);
        if (vec_rd[i] != '0) begin
          exp_regs[vec_rd[i]] = vec_exp[i];
        end
      end
      gap = int'($unsigned($random(seed)) % 3);   // Zero gives back-to-back requests
      repeat (gap) begin
        @(posedge clk_i);
        ctrl_valid_i <= 1'b0;
      end
    end
    @(posedge clk_i);
    ctrl_valid_i <= 1'b0;

    // Drain outstanding loads and the late flag checks
    while (exp_data_q.size() != 0) begin
      @(posedge clk_i);
    end
    repeat (`LSU_LOAD_LATENCY + 1) @(posedge clk_i);

    // Register file contents including x0
    for (int r = 0; r < `LSU_REG_COUNT; r++) begin
      @(posedge clk_i);
      rf_raddr_i <= reg_idx_t'(r);
      @(negedge clk_i);
      chk_cnt++;
      if (rf_rdata_o !== exp_regs[r]) begin
        report_mismatch($sformatf("rf_rdata_o[x%0d]", r), exp_regs[r], rf_rdata_o);
      end
    end

    $display("Checks: %0d  Errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
